/* common/wsched_pkg.sv */
package wsched_pkg;

    localparam int num_warps    = 4;
    localparam int num_threads  = 4;
    localparam int addr_width   = 32;
    localparam int nw_bits      = 2;
    localparam int num_barriers = 2;
    localparam int nb_bits      = 1;
    localparam int stack_depth  = 8;

    // pc of warp 0 out of reset
    localparam logic [addr_width-1:0] startup_addr = 32'h8000_0000;

    typedef enum logic [2:0] {
        ctl_none,
        ctl_wspawn,
        ctl_tmc,
        ctl_split,
        ctl_bar
    } ctl_op_e;

    // one reconvergence stack entry
    typedef struct packed {
        logic [addr_width-1:0]  pc;
        logic [num_threads-1:0] tmask;
    } ipdom_entry_t;

endpackage

/* common/warp_ctl_if.sv */
`timescale 1ns/1ps

interface warp_ctl_if;

    logic                                 valid;
    wsched_pkg::ctl_op_e                  op;
    logic [wsched_pkg::nw_bits-1:0]       wid;
    logic [wsched_pkg::num_threads-1:0]   tmask;
    // spawn pc on wspawn, else pc on split
    logic [wsched_pkg::addr_width-1:0]    pc;
    logic [wsched_pkg::num_threads-1:0]   then_tmask;
    logic [wsched_pkg::num_threads-1:0]   else_tmask;
    logic                                 diverged;
    logic                                 bar_release;
    logic [wsched_pkg::num_warps-1:0]     spawn_mask;

    modport ctl (
        output valid, op, wid, tmask, pc,
        output then_tmask, else_tmask, diverged,
        output bar_release, spawn_mask
    );

    modport slot (
        input valid, op, wid, tmask, pc,
        input then_tmask, else_tmask, diverged,
        input bar_release, spawn_mask
    );

endinterface

/* common/warp_status_if.sv */
`timescale 1ns/1ps

// one instance per warp
interface warp_status_if;

    logic                               ready;
    logic [wsched_pkg::addr_width-1:0]  pc;
    logic [wsched_pkg::num_threads-1:0] tmask;
    logic                               grant;

    modport slot (
        output ready, pc, tmask,
        input  grant
    );

    modport select (
        input  ready, pc, tmask,
        output grant
    );

endinterface

/* logic/ipdom_stack.sv */
`timescale 1ns/1ps

module ipdom_stack (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  logic                     pair,
    input  logic                     pop,
    input  wsched_pkg::ipdom_entry_t q_end,
    input  wsched_pkg::ipdom_entry_t q_else,
    output wsched_pkg::ipdom_entry_t d,
    output logic                     index
);

    wsched_pkg::ipdom_entry_t end_mem  [wsched_pkg::stack_depth];
    wsched_pkg::ipdom_entry_t else_mem [wsched_pkg::stack_depth];
    logic [wsched_pkg::stack_depth-1:0]          else_taken;
    logic [$clog2(wsched_pkg::stack_depth):0]    count;
    logic [$clog2(wsched_pkg::stack_depth)-1:0]  wr_ptr;
    logic [$clog2(wsched_pkg::stack_depth)-1:0]  top;
    logic                                        full;
    logic                                        empty;

    assign wr_ptr = count[$clog2(wsched_pkg::stack_depth)-1:0];
    assign top    = wr_ptr - 1'b1;
    assign full   = (count == wsched_pkg::stack_depth);
    assign empty  = (count == '0);

    // low index means the else side is still pending on this level
    assign index = else_taken[top];
    assign d     = index ? end_mem[top] : else_mem[top];

    always_ff @(posedge clk) begin
        if (push) begin
            end_mem[wr_ptr]    <= q_end;
            else_mem[wr_ptr]   <= q_else;
            // single push has no else side to visit
            else_taken[wr_ptr] <= !pair;
        end else if (pop && !else_taken[top]) begin
            else_taken[top] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (push) begin
            count <= count + 1'b1;
        end else if (pop && else_taken[top]) begin
            count <= count - 1'b1;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

/* warp_sched/warp_ctl_unit.sv */
`timescale 1ns/1ps

module warp_ctl_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ctl_valid,
    input  wsched_pkg::ctl_op_e                 ctl_op,
    input  logic [wsched_pkg::nw_bits-1:0]      ctl_wid,
    input  logic [wsched_pkg::num_threads-1:0]  ctl_tmask,
    input  logic [wsched_pkg::addr_width-1:0]   ctl_pc,
    input  logic [wsched_pkg::num_threads-1:0]  ctl_then_tmask,
    input  logic [wsched_pkg::num_threads-1:0]  ctl_else_tmask,
    input  logic                                ctl_diverged,
    input  logic [wsched_pkg::nb_bits-1:0]      ctl_bar_id,
    input  logic [wsched_pkg::nw_bits-1:0]      ctl_bar_size_m1,
    output logic [wsched_pkg::num_warps-1:0]    barrier_stall,
    warp_ctl_if.ctl                             ctl
);

    logic [wsched_pkg::num_warps-1:0] barrier_masks [wsched_pkg::num_barriers];
    logic [wsched_pkg::nw_bits:0]     bar_count;
    logic                             bar_cmd;
    logic                             bar_reached;
    logic                             spawn_cmd;

    assign bar_cmd   = ctl_valid && (ctl_op == wsched_pkg::ctl_bar);
    assign spawn_cmd = ctl_valid && (ctl_op == wsched_pkg::ctl_wspawn);

    // warps already waiting on the addressed barrier
    always_comb begin
        bar_count = '0;
        for (int i = 0; i < wsched_pkg::num_warps; i++) begin
            bar_count = bar_count + (wsched_pkg::nw_bits + 1)'(barrier_masks[ctl_bar_id][i]);
        end
    end

    assign bar_reached = (bar_count == {1'b0, ctl_bar_size_m1});

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < wsched_pkg::num_barriers; b++) begin
                barrier_masks[b] <= '0;
            end
        end else if (bar_cmd) begin
            if (bar_reached) begin
                barrier_masks[ctl_bar_id] <= '0;
            end else begin
                barrier_masks[ctl_bar_id][ctl_wid] <= 1'b1;
            end
        end
    end

    always_comb begin
        barrier_stall = '0;
        for (int b = 0; b < wsched_pkg::num_barriers; b++) begin
            barrier_stall = barrier_stall | barrier_masks[b];
        end
    end

    assign ctl.valid       = ctl_valid;
    assign ctl.op          = ctl_op;
    assign ctl.wid         = ctl_wid;
    assign ctl.tmask       = ctl_tmask;
    assign ctl.pc          = ctl_pc;
    assign ctl.then_tmask  = ctl_then_tmask;
    assign ctl.else_tmask  = ctl_else_tmask;
    assign ctl.diverged    = ctl_diverged;
    assign ctl.bar_release = bar_cmd && bar_reached;

    // wspawn carries its warp mask in the tmask field, warp 0 never respawns
    assign ctl.spawn_mask = spawn_cmd
                          ? (wsched_pkg::num_warps'(ctl_tmask) & ~wsched_pkg::num_warps'(1))
                          : '0;

    a_op_valid: assert property (
        @(posedge clk) disable iff (reset) ctl_valid |-> (ctl_op != wsched_pkg::ctl_none));

endmodule

/* warp_sched/warp_slot.sv */
`timescale 1ns/1ps

module warp_slot (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [wsched_pkg::nw_bits-1:0]      slot_id,
    warp_ctl_if.slot                            ctl,
    warp_status_if.slot                         status,
    input  logic                                barrier_stall,
    input  logic                                branch_valid,
    input  logic [wsched_pkg::nw_bits-1:0]      branch_wid,
    input  logic                                branch_taken,
    input  logic [wsched_pkg::addr_width-1:0]   branch_dest,
    input  logic                                join_valid,
    input  logic [wsched_pkg::nw_bits-1:0]      join_wid,
    input  logic                                wstall_valid,
    input  logic [wsched_pkg::nw_bits-1:0]      wstall_wid,
    input  logic                                wstall_stalled,
    input  logic                                fire_valid,
    input  logic [wsched_pkg::nw_bits-1:0]      fire_wid,
    input  logic [wsched_pkg::addr_width-1:0]   fire_pc,
    output logic                                active
);

    logic                               stalled;
    logic                               spawn_pending;
    logic [wsched_pkg::addr_width-1:0]  pc;
    logic [wsched_pkg::addr_width-1:0]  spawn_pc;
    logic [wsched_pkg::num_threads-1:0] tmask;
    logic                               own_cmd;
    logic                               spawn_hit;
    logic                               split_push;
    logic                               join_pop;
    logic                               join_index;
    wsched_pkg::ipdom_entry_t           q_end;
    wsched_pkg::ipdom_entry_t           q_else;
    wsched_pkg::ipdom_entry_t           join_entry;

    assign own_cmd    = ctl.valid && (ctl.wid == slot_id);
    assign spawn_hit  = ctl.spawn_mask[slot_id];
    assign split_push = own_cmd && (ctl.op == wsched_pkg::ctl_split);
    assign join_pop   = join_valid && (join_wid == slot_id);

    // end entry keeps the mask to restore at reconvergence
    assign q_end  = '{pc: pc, tmask: tmask};
    assign q_else = '{pc: ctl.pc, tmask: ctl.else_tmask};

    ipdom_stack ipdom_stack_i (
        .clk    (clk),
        .reset  (reset),
        .push   (split_push),
        .pair   (ctl.diverged),
        .pop    (join_pop),
        .q_end  (q_end),
        .q_else (q_else),
        .d      (join_entry),
        .index  (join_index)
    );

    always_ff @(posedge clk) begin
        if (spawn_hit) begin
            spawn_pc <= ctl.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active        <= (slot_id == '0);
            stalled       <= 1'b0;
            spawn_pending <= 1'b0;
            pc            <= wsched_pkg::startup_addr;
            tmask         <= wsched_pkg::num_threads'(slot_id == '0);
        end else begin
            if (own_cmd) begin
                case (ctl.op)
                    wsched_pkg::ctl_tmc: begin
                        tmask   <= ctl.tmask;
                        active  <= |ctl.tmask;
                        stalled <= 1'b0;
                    end
                    wsched_pkg::ctl_split: begin
                        if (ctl.diverged) begin
                            tmask <= ctl.then_tmask;
                        end
                        stalled <= 1'b0;
                    end
                    wsched_pkg::ctl_bar: begin
                        stalled <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end

            if (spawn_hit) begin
                active        <= 1'b1;
                stalled       <= 1'b0;
                spawn_pending <= 1'b1;
            end

            // waiting warps leave the barrier unstalled
            if (ctl.bar_release && barrier_stall) begin
                stalled <= 1'b0;
            end

            if (branch_valid && (branch_wid == slot_id)) begin
                if (branch_taken) begin
                    pc <= branch_dest;
                end
                stalled <= 1'b0;
            end

            // held until decode reports back
            if (status.grant) begin
                stalled       <= 1'b1;
                spawn_pending <= 1'b0;
                if (spawn_pending) begin
                    tmask <= wsched_pkg::num_threads'(1);
                end
            end

            if (fire_valid && (fire_wid == slot_id)) begin
                pc <= fire_pc + wsched_pkg::addr_width'(4);
            end

            if (wstall_valid && (wstall_wid == slot_id)) begin
                stalled <= wstall_stalled;
            end

            if (join_pop) begin
                if (!join_index) begin
                    pc <= join_entry.pc;
                end
                tmask <= join_entry.tmask;
            end
        end
    end

    assign status.ready = active && !stalled && !barrier_stall;
    assign status.pc    = spawn_pending ? spawn_pc : pc;
    assign status.tmask = spawn_pending ? wsched_pkg::num_threads'(1) : tmask;

endmodule

/* warp_sched/warp_select.sv */
`timescale 1ns/1ps

module warp_select (
    input  logic                                clk,
    input  logic                                reset,
    warp_status_if.select                       status [wsched_pkg::num_warps],
    input  logic                                fetch_ready,
    output logic                                fetch_valid,
    output logic [wsched_pkg::nw_bits-1:0]      fetch_wid,
    output logic [wsched_pkg::addr_width-1:0]   fetch_pc,
    output logic [wsched_pkg::num_threads-1:0]  fetch_tmask
);

    logic [wsched_pkg::num_warps-1:0]   ready_vec;
    logic [wsched_pkg::num_warps-1:0]   grant;
    logic [wsched_pkg::addr_width-1:0]  pc_arr    [wsched_pkg::num_warps];
    logic [wsched_pkg::num_threads-1:0] tmask_arr [wsched_pkg::num_warps];
    logic [wsched_pkg::nw_bits-1:0]     sel_wid;
    logic                               sel_valid;
    logic                               stall_out;

    for (genvar i = 0; i < wsched_pkg::num_warps; i++) begin : g_status
        assign ready_vec[i]    = status[i].ready;
        assign pc_arr[i]       = status[i].pc;
        assign tmask_arr[i]    = status[i].tmask;
        assign status[i].grant = grant[i];
    end

    // lowest index wins
    always_comb begin
        sel_valid = 1'b0;
        sel_wid   = '0;
        for (int i = wsched_pkg::num_warps - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                sel_valid = 1'b1;
                sel_wid   = wsched_pkg::nw_bits'(i);
            end
        end
    end

    assign stall_out = fetch_valid && !fetch_ready;
    assign grant     = (sel_valid && !stall_out) ? (wsched_pkg::num_warps'(1) << sel_wid) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else if (!stall_out) begin
            fetch_valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_out) begin
            fetch_wid   <= sel_wid;
            fetch_pc    <= pc_arr[sel_wid];
            fetch_tmask <= tmask_arr[sel_wid];
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        stall_out |=> fetch_valid && $stable({fetch_wid, fetch_pc, fetch_tmask}));

endmodule

/* warp_sched/warp_sched_top.sv */
`timescale 1ns/1ps

module warp_sched_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ctl_valid,
    input  wsched_pkg::ctl_op_e                 ctl_op,
    input  logic [wsched_pkg::nw_bits-1:0]      ctl_wid,
    input  logic [wsched_pkg::num_threads-1:0]  ctl_tmask,
    input  logic [wsched_pkg::addr_width-1:0]   ctl_pc,
    input  logic [wsched_pkg::num_threads-1:0]  ctl_then_tmask,
    input  logic [wsched_pkg::num_threads-1:0]  ctl_else_tmask,
    input  logic                                ctl_diverged,
    input  logic [wsched_pkg::nb_bits-1:0]      ctl_bar_id,
    input  logic [wsched_pkg::nw_bits-1:0]      ctl_bar_size_m1,
    input  logic                                branch_valid,
    input  logic [wsched_pkg::nw_bits-1:0]      branch_wid,
    input  logic                                branch_taken,
    input  logic [wsched_pkg::addr_width-1:0]   branch_dest,
    input  logic                                join_valid,
    input  logic [wsched_pkg::nw_bits-1:0]      join_wid,
    input  logic                                wstall_valid,
    input  logic [wsched_pkg::nw_bits-1:0]      wstall_wid,
    input  logic                                wstall_stalled,
    output logic                                fetch_valid,
    input  logic                                fetch_ready,
    output logic [wsched_pkg::nw_bits-1:0]      fetch_wid,
    output logic [wsched_pkg::addr_width-1:0]   fetch_pc,
    output logic [wsched_pkg::num_threads-1:0]  fetch_tmask,
    output logic                                busy
);

    logic [wsched_pkg::num_warps-1:0] barrier_stall;
    logic [wsched_pkg::num_warps-1:0] warp_active;
    logic                             fire;

    warp_ctl_if    ctl_bus ();
    warp_status_if status_bus [wsched_pkg::num_warps] ();

    assign fire = fetch_valid && fetch_ready;
    assign busy = |warp_active;

    warp_ctl_unit warp_ctl_unit_i (
        .clk             (clk),
        .reset           (reset),
        .ctl_valid       (ctl_valid),
        .ctl_op          (ctl_op),
        .ctl_wid         (ctl_wid),
        .ctl_tmask       (ctl_tmask),
        .ctl_pc          (ctl_pc),
        .ctl_then_tmask  (ctl_then_tmask),
        .ctl_else_tmask  (ctl_else_tmask),
        .ctl_diverged    (ctl_diverged),
        .ctl_bar_id      (ctl_bar_id),
        .ctl_bar_size_m1 (ctl_bar_size_m1),
        .barrier_stall   (barrier_stall),
        .ctl             (ctl_bus)
    );

    for (genvar i = 0; i < wsched_pkg::num_warps; i++) begin : g_slot
        warp_slot warp_slot_i (
            .clk            (clk),
            .reset          (reset),
            .slot_id        (wsched_pkg::nw_bits'(i)),
            .ctl            (ctl_bus),
            .status         (status_bus[i]),
            .barrier_stall  (barrier_stall[i]),
            .branch_valid   (branch_valid),
            .branch_wid     (branch_wid),
            .branch_taken   (branch_taken),
            .branch_dest    (branch_dest),
            .join_valid     (join_valid),
            .join_wid       (join_wid),
            .wstall_valid   (wstall_valid),
            .wstall_wid     (wstall_wid),
            .wstall_stalled (wstall_stalled),
            .fire_valid     (fire),
            .fire_wid       (fetch_wid),
            .fire_pc        (fetch_pc),
            .active         (warp_active[i])
        );
    end

    warp_select warp_select_i (
        .clk         (clk),
        .reset       (reset),
        .status      (status_bus),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_wid   (fetch_wid),
        .fetch_pc    (fetch_pc),
        .fetch_tmask (fetch_tmask)
    );

endmodule

/* test/warp_sched_model.svh */
`ifndef WARP_SCHED_MODEL_SVH
`define WARP_SCHED_MODEL_SVH

logic                   m_active  [nw];
logic                   m_stalled [nw];
logic                   m_sp      [nw];
logic [aw-1:0]          m_pc      [nw];
logic [aw-1:0]          m_spc     [nw];
logic [nt-1:0]          m_tm      [nw];
logic [nw-1:0]          m_bar     [wsched_pkg::num_barriers];
logic [aw-1:0]          st_epc    [nw][depth];
logic [aw-1:0]          st_lpc    [nw][depth];
logic [nt-1:0]          st_etm    [nw][depth];
logic [nt-1:0]          st_ltm    [nw][depth];
logic                   st_taken  [nw][depth];
int                     st_cnt    [nw];
logic                   m_fv;
logic [1:0]             m_fw;
logic [aw-1:0]          m_fpc;
logic [nt-1:0]          m_ftm;

task automatic model_reset();
    for (int w = 0; w < nw; w++) begin
        m_active[w]  = (w == 0);
        m_stalled[w] = 1'b0;
        m_sp[w]      = 1'b0;
        m_pc[w]      = wsched_pkg::startup_addr;
        m_tm[w]      = nt'(w == 0);
        st_cnt[w]    = 0;
    end
    for (int b = 0; b < wsched_pkg::num_barriers; b++) begin
        m_bar[b] = '0;
    end
    m_fv = 1'b0;
endtask

function automatic logic bar_waiting(int w);
    logic any;
    any = 1'b0;
    for (int b = 0; b < wsched_pkg::num_barriers; b++) begin
        any = any | m_bar[b][w];
    end
    return any;
endfunction

// one clock edge of the scheduler, from the inputs applied in this cycle
task automatic model_step();
    logic          old_bst [nw];
    logic [aw-1:0] old_pc  [nw];
    logic [aw-1:0] old_spc [nw];
    logic [nt-1:0] old_tm  [nw];
    logic          old_sp  [nw];
    logic [1:0]    old_fw;
    logic [aw-1:0] old_fpc;
    logic          release_bar;
    logic          hold;
    logic          fire;
    logic          own;
    int            sel;
    int            grant_w;
    int            top;
    sel = -1;
    for (int w = nw - 1; w >= 0; w--) begin
        old_bst[w] = bar_waiting(w);
        old_pc[w]  = m_pc[w];
        old_spc[w] = m_spc[w];
        old_tm[w]  = m_tm[w];
        old_sp[w]  = m_sp[w];
        if (m_active[w] && !m_stalled[w] && !old_bst[w]) begin
            sel = w;
        end
    end
    hold    = m_fv && !fetch_ready;
    fire    = m_fv && fetch_ready;
    grant_w = hold ? -1 : sel;
    old_fw  = m_fw;
    old_fpc = m_fpc;
    release_bar = 1'b0;
    if (ctl_valid && ctl_op == wsched_pkg::ctl_bar) begin
        if ($countones(m_bar[ctl_bar_id]) == ctl_bar_size_m1) begin
            release_bar = 1'b1;
            m_bar[ctl_bar_id] = '0;
        end else begin
            m_bar[ctl_bar_id][ctl_wid] = 1'b1;
        end
    end
    for (int w = 0; w < nw; w++) begin
        own = ctl_valid && (ctl_wid == w);
        if (own && ctl_op == wsched_pkg::ctl_tmc) begin
            m_tm[w]      = ctl_tmask;
            m_active[w]  = |ctl_tmask;
            m_stalled[w] = 1'b0;
        end
        if (own && ctl_op == wsched_pkg::ctl_split) begin
            top = st_cnt[w];
            st_epc[w][top]   = old_pc[w];
            st_etm[w][top]   = old_tm[w];
            st_lpc[w][top]   = ctl_pc;
            st_ltm[w][top]   = ctl_else_tmask;
            st_taken[w][top] = !ctl_diverged;
            st_cnt[w]++;
            if (ctl_diverged) begin
                m_tm[w] = ctl_then_tmask;
            end
            m_stalled[w] = 1'b0;
        end
        if (own && ctl_op == wsched_pkg::ctl_bar) begin
            m_stalled[w] = 1'b0;
        end
        if (ctl_valid && ctl_op == wsched_pkg::ctl_wspawn && w != 0 && ctl_tmask[w]) begin
            m_active[w]  = 1'b1;
            m_stalled[w] = 1'b0;
            m_sp[w]      = 1'b1;
            m_spc[w]     = ctl_pc;
        end
        if (release_bar && old_bst[w]) begin
            m_stalled[w] = 1'b0;
        end
        if (branch_valid && branch_wid == w) begin
            if (branch_taken) begin
                m_pc[w] = branch_dest;
            end
            m_stalled[w] = 1'b0;
        end
        if (grant_w == w) begin
            m_stalled[w] = 1'b1;
            m_sp[w]      = 1'b0;
            if (old_sp[w]) begin
                m_tm[w] = nt'(1);
            end
        end
        if (fire && old_fw == w) begin
            m_pc[w] = old_fpc + 32'd4;
        end
        if (wstall_valid && wstall_wid == w) begin
            m_stalled[w] = wstall_stalled;
        end
        if (join_valid && join_wid == w) begin
            top = st_cnt[w] - 1;
            if (!st_taken[w][top]) begin
                m_pc[w] = st_lpc[w][top];
                m_tm[w] = st_ltm[w][top];
                st_taken[w][top] = 1'b1;
            end else begin
                m_tm[w] = st_etm[w][top];
                st_cnt[w]--;
            end
        end
    end
    if (!hold) begin
        m_fv = (sel >= 0);
        if (sel >= 0) begin
            m_fw  = 2'(sel);
            m_fpc = old_sp[sel] ? old_spc[sel] : old_pc[sel];
            m_ftm = old_sp[sel] ? nt'(1) : old_tm[sel];
        end
    end
endtask

`endif

/* test/warp_sched_tb.sv */
`timescale 1ns/1ps

module warp_sched_tb;

    localparam int nw          = wsched_pkg::num_warps;
    localparam int nt          = wsched_pkg::num_threads;
    localparam int aw          = wsched_pkg::addr_width;
    localparam int depth       = wsched_pkg::stack_depth;
    localparam int test_cycles = 400;
    localparam int kill_cycles = 60;
    localparam int total_cycles = 6 * (test_cycles + 3) + kill_cycles;

    logic clk;
    logic reset;
    logic ctl_valid;
    wsched_pkg::ctl_op_e ctl_op;
    logic [1:0] ctl_wid;
    logic [nt-1:0] ctl_tmask;
    logic [aw-1:0] ctl_pc;
    logic [nt-1:0] ctl_then_tmask;
    logic [nt-1:0] ctl_else_tmask;
    logic ctl_diverged;
    logic [wsched_pkg::nb_bits-1:0] ctl_bar_id;
    logic [1:0] ctl_bar_size_m1;
    logic branch_valid;
    logic [1:0] branch_wid;
    logic branch_taken;
    logic [aw-1:0] branch_dest;
    logic join_valid;
    logic [1:0] join_wid;
    logic wstall_valid;
    logic [1:0] wstall_wid;
    logic wstall_stalled;
    logic fetch_valid;
    logic fetch_ready;
    logic [1:0] fetch_wid;
    logic [aw-1:0] fetch_pc;
    logic [nt-1:0] fetch_tmask;
    logic busy;

    integer seed = 32'hac87_35e9;
    int mode;
    int tcyc;
    int fires;
    int errors;
    int checks;
    logic model_ok;
    logic prev_hold;
    logic [1:0] prev_wid;
    logic [aw-1:0] prev_pc;
    logic [nt-1:0] prev_tmask;
    int resp_due [$];
    int resp_wid [$];

    `include "warp_sched_model.svh"

    warp_sched_top warp_sched_top_i (.*);

    always #5 clk = !clk;

    task automatic check_value(string name, logic [aw-1:0] got, logic [aw-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [aw-1:0] rand_pc();
        return {$random(seed)} & 32'hffff_fffc;
    endfunction

    task automatic issue_command();
        int w;
        int kind;
        int n_act;
        logic found;
        w = {$random(seed)} % nw;
        kind = {$random(seed)} % 3;
        n_act = 0;
        found = 1'b0;
        for (int i = nw - 1; i >= 0; i--) begin
            n_act += m_active[i];
            if (m_active[i]) begin
                found = 1'b1;
                if (mode == 7) w = i;
            end
        end
        ctl_wid <= 2'(w);
        if (tcyc == 3 && (mode == 2 || mode == 3 || mode == 5 || mode == 6)) begin
            ctl_valid <= 1'b1;
            ctl_op    <= wsched_pkg::ctl_wspawn;
            ctl_tmask <= (mode == 5) ? 4'hf : nt'({$random(seed)} | 2);
            ctl_pc    <= rand_pc();
        end else if (mode == 7) begin
            // kill phase, one tmc of zero per cycle
            ctl_valid <= found;
            ctl_op    <= wsched_pkg::ctl_tmc;
            ctl_tmask <= '0;
        end else if ({$random(seed)} % 6 == 0 && m_active[w]) begin
            if (mode == 3 || (mode == 6 && kind == 0)) begin
                ctl_valid <= 1'b1;
                ctl_op    <= wsched_pkg::ctl_tmc;
                ctl_tmask <= nt'({$random(seed)} % 15 + 1);
            end else if ((mode == 4 || (mode == 6 && kind == 1)) && st_cnt[w] < depth) begin
                ctl_valid      <= 1'b1;
                ctl_op         <= wsched_pkg::ctl_split;
                ctl_diverged   <= 1'($random(seed));
                ctl_then_tmask <= nt'($random(seed));
                ctl_else_tmask <= nt'($random(seed));
                ctl_pc         <= rand_pc();
            end else if ((mode == 5 || (mode == 6 && kind == 2)) && !bar_waiting(w)) begin
                ctl_valid       <= 1'b1;
                ctl_op          <= wsched_pkg::ctl_bar;
                ctl_bar_id      <= wsched_pkg::nb_bits'($random(seed));
                ctl_bar_size_m1 <= 2'({$random(seed)} % n_act);
            end
        end
    endtask

    task automatic drive_next();
        int w;
        int kind;
        logic spawn_now;
        spawn_now = (tcyc == 3) && (mode == 2 || mode == 3 || mode == 5 || mode == 6);
        ctl_valid    <= 1'b0;
        branch_valid <= 1'b0;
        join_valid   <= 1'b0;
        wstall_valid <= 1'b0;
        fetch_ready  <= ({$random(seed)} % ((mode == 6) ? 2 : 4)) != 0;
        // the spawn cycle goes ahead of any response
        if (!spawn_now && resp_due.size() > 0 && resp_due[0] <= tcyc) begin
            void'(resp_due.pop_front());
            w = resp_wid.pop_front();
            kind = {$random(seed)} % 3;
            if (kind == 2 && st_cnt[w] > 0) begin
                join_valid <= 1'b1;
                join_wid   <= 2'(w);
                // a join leaves the warp stalled, release it afterwards
                resp_due.push_back(tcyc + 1);
                resp_wid.push_back(w);
            end else if (kind == 1) begin
                branch_valid <= 1'b1;
                branch_wid   <= 2'(w);
                branch_taken <= 1'($random(seed));
                branch_dest  <= rand_pc();
            end else begin
                wstall_valid   <= 1'b1;
                wstall_wid     <= 2'(w);
                wstall_stalled <= 1'b0;
            end
        end else begin
            issue_command();
        end
    endtask

    always @(posedge clk) begin
        if (!reset && model_ok) begin
            check_value("fetch_valid", fetch_valid, m_fv);
            check_value("busy", busy, (m_active[0] | m_active[1] | m_active[2] | m_active[3]));
            if (m_fv) begin
                check_value("fetch_wid", fetch_wid, m_fw);
                check_value("fetch_pc", fetch_pc, m_fpc);
                check_value("fetch_tmask", fetch_tmask, m_ftm);
            end
            if (prev_hold) begin
                check_value("held fetch_valid", fetch_valid, 1'b1);
                check_value("held fetch_wid", fetch_wid, prev_wid);
                check_value("held fetch_pc", fetch_pc, prev_pc);
                check_value("held fetch_tmask", fetch_tmask, prev_tmask);
            end
        end
        prev_hold  = fetch_valid && !fetch_ready;
        prev_wid   = fetch_wid;
        prev_pc    = fetch_pc;
        prev_tmask = fetch_tmask;
        if (reset) begin
            model_reset();
            model_ok = 1'b1;
            tcyc = 0;
            fires = 0;
            resp_due.delete();
            resp_wid.delete();
            ctl_valid <= 1'b0;
            branch_valid <= 1'b0;
            join_valid <= 1'b0;
            wstall_valid <= 1'b0;
            fetch_ready <= 1'b1;
        end else begin
            if (fetch_valid && fetch_ready) begin
                if (mode == 1 && fires == 0) begin
                    check_value("first fetch_wid", fetch_wid, 0);
                    check_value("first fetch_pc", fetch_pc, wsched_pkg::startup_addr);
                    check_value("first fetch_tmask", fetch_tmask, 1);
                    check_value("first busy", busy, 1);
                end
                fires++;
                resp_due.push_back(tcyc + 1 + {$random(seed)} % 3);
                resp_wid.push_back(fetch_wid);
            end
            model_step();
            tcyc++;
            drive_next();
        end
    end

    task automatic run_test(int t);
        int err0;
        int fires_before;
        err0 = errors;
        @(posedge clk);
        mode  <= t;
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (test_cycles) @(posedge clk);
        if (t == 3) begin
            mode <= 7;
            repeat (kill_cycles - 20) @(posedge clk);
            @(negedge clk);
            fires_before = fires;
            repeat (20) @(negedge clk);
            if (busy !== 1'b0) begin
                errors++;
                $display("busy still high after every warp got a zero tmc");
            end
            if (fires != fires_before) begin
                errors++;
                $display("fetches kept firing after every warp was deactivated");
            end
        end
        $display("test %0d done: %0d fetches, %0d errors", t, fires, errors - err0);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        mode = 0;
        errors = 0;
        checks = 0;
        model_ok = 1'b0;
        prev_hold = 1'b0;
        ctl_valid = 1'b0;
        ctl_op = wsched_pkg::ctl_tmc;
        ctl_wid = '0;
        ctl_tmask = '0;
        ctl_pc = '0;
        ctl_then_tmask = '0;
        ctl_else_tmask = '0;
        ctl_diverged = 1'b0;
        ctl_bar_id = '0;
        ctl_bar_size_m1 = '0;
        branch_valid = 1'b0;
        branch_wid = '0;
        branch_taken = 1'b0;
        branch_dest = '0;
        join_valid = 1'b0;
        join_wid = '0;
        wstall_valid = 1'b0;
        wstall_wid = '0;
        wstall_stalled = 1'b0;
        fetch_ready = 1'b1;
        for (int t = 1; t <= 6; t++) begin
            run_test(t);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(20 * total_cycles);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+test
common/wsched_pkg.sv
common/warp_ctl_if.sv
common/warp_status_if.sv
logic/ipdom_stack.sv
warp_sched/warp_ctl_unit.sv
warp_sched/warp_slot.sv
warp_sched/warp_select.sv
warp_sched/warp_sched_top.sv
test/warp_sched_tb.sv
